// ==== vlsu_pkg.sv ====
// vector load/store unit package
// shared widths, encodings, fault codes and the queued request state
`default_nettype none

package vlsu_pkg;

    // memory port geometry
    localparam int unsigned VMEM_W = 32;
    localparam int unsigned VMEM_B = VMEM_W / 8;
    localparam int unsigned OFF_W  = $clog2(VMEM_B);
    localparam int unsigned ID_W   = 3;

    localparam int unsigned QUEUE_DEPTH_DEF = 4;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic {
        STRIDE_UNIT  = 1'b0,
        STRIDE_CONST = 1'b1
    } stride_e;

    // access faults raised on a bus error
    localparam logic [5:0] EXC_LOAD_FAULT  = 6'd5;
    localparam logic [5:0] EXC_STORE_FAULT = 6'd7;

    // per-beat state kept until the memory result arrives
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic              first;
        logic              last;
        logic              store;
        stride_e           stride;
        eew_e              eew;
        logic              masked;
        logic [OFF_W-1:0]  vl_part;
        logic              vl_zero;
        logic [OFF_W-1:0]  off;
        logic [VMEM_B-1:0] mask;
    } lsu_state_t;

endpackage

`default_nettype wire

// ==== vlsu_addr_gen.sv ====
// address, write data and byte-enable composition for one beat
// unit-stride and constant-stride modes, purely combinational
`timescale 1ns/1ps
`default_nettype none

module vlsu_addr_gen import vlsu_pkg::*; (
    input  logic              in_first_i,
    input  stride_e           in_stride_i,
    input  eew_e              in_eew_i,
    input  logic              in_masked_i,
    input  logic [31:0]       in_xval_i,
    input  logic [VMEM_W-1:0] in_vs_i,
    input  logic [VMEM_B-1:0] in_mask_i,
    input  logic [OFF_W-1:0]  in_vl_part_i,
    input  logic              in_vl_zero_i,
    input  logic              in_valid_i,
    input  logic [31:0]       prev_addr_i,
    output logic [31:0]       addr_o,
    output logic [VMEM_W-1:0] wdata_o,
    output logic [VMEM_B-1:0] be_o
);

    logic [31:0]       addr_inc;
    logic [OFF_W-1:0]  off;
    logic [VMEM_B-1:0] vl_mask;
    logic              stri_en;

    ////////////////////////////////////////////////////////////
    // address

    // xval is the base on the first beat and the stride afterwards
    assign addr_inc = (in_stride_i == STRIDE_UNIT) ? 32'(VMEM_B) : in_xval_i;

    always_comb begin
        addr_o = prev_addr_i;
        if (in_valid_i) begin
            addr_o = in_first_i ? in_xval_i : prev_addr_i + addr_inc;
        end
    end

    assign off = addr_o[OFF_W-1:0];

    ////////////////////////////////////////////////////////////
    // write data and byte enables

    // bytes up to vl_part are inside the vector length
    assign vl_mask = in_vl_zero_i ? '0 : ({VMEM_B{1'b1}} >> (~in_vl_part_i));
    assign stri_en = ~in_vl_zero_i & (in_masked_i ? in_mask_i[0] : 1'b1);

    always_comb begin
        wdata_o = in_vs_i;
        be_o    = (in_masked_i ? in_mask_i : {VMEM_B{1'b1}}) & vl_mask;
        if (in_stride_i == STRIDE_CONST) begin
            // low element copied to every lane, enable only at its own lane
            unique case (in_eew_i)
                EEW_8: begin
                    wdata_o = {VMEM_B{in_vs_i[7:0]}};
                    be_o    = VMEM_B'(stri_en) << off;
                end
                EEW_16: begin
                    wdata_o = {(VMEM_B / 2){in_vs_i[15:0]}};
                    be_o    = VMEM_B'({2{stri_en}}) << (off & ~OFF_W'(1));
                end
                default: begin
                    wdata_o = {(VMEM_B / 4){in_vs_i[31:0]}};
                    be_o    = VMEM_B'({4{stri_en}}) << (off & ~OFF_W'(3));
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== vlsu_queue.sv ====
// circular FIFO for request state between issue and memory result
`timescale 1ns/1ps
`default_nettype none

module vlsu_queue #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             async_rst_ni,
    input  logic             enq_valid_i,
    output logic             enq_ready_o,
    input  logic [WIDTH-1:0] enq_data_i,
    output logic             deq_valid_o,
    input  logic             deq_ready_i,
    output logic [WIDTH-1:0] deq_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             enq;
    logic             deq;

    assign enq_ready_o = cnt_q != CNT_W'(DEPTH);
    assign deq_valid_o = cnt_q != '0;
    assign deq_data_o  = mem_q[rd_ptr_q];

    assign enq = enq_valid_i & enq_ready_o;
    assign deq = deq_ready_i & deq_valid_o;

    always_ff @(posedge clk_i) begin
        if (enq) begin
            mem_q[wr_ptr_q] <= enq_data_i;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(enq) - CNT_W'(deq);
        end
    end

endmodule

`default_nettype wire

// ==== vlsu_req_stage.sv ====
// execute stage of the load/store unit
// holds the request register, drives the memory request, enqueues beat state
`timescale 1ns/1ps
`default_nettype none

module vlsu_req_stage import vlsu_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  logic              in_first_i,
    input  logic              in_last_i,
    input  logic              in_store_i,
    input  stride_e           in_stride_i,
    input  eew_e              in_eew_i,
    input  logic              in_masked_i,
    input  logic [31:0]       in_xval_i,
    input  logic [VMEM_W-1:0] in_vs_i,
    input  logic [VMEM_B-1:0] in_mask_i,
    input  logic [OFF_W-1:0]  in_vl_part_i,
    input  logic              in_vl_zero_i,
    output logic              mem_valid_o,
    input  logic              mem_ready_i,
    output logic [31:0]       mem_addr_o,
    output logic              mem_we_o,
    output logic [VMEM_B-1:0] mem_be_o,
    output logic [VMEM_W-1:0] mem_wdata_o,
    output logic              mem_last_o,
    output logic              deq_valid_o,
    input  logic              deq_ready_i,
    output lsu_state_t        deq_state_o
);

    logic [31:0]       addr_d;
    logic [VMEM_W-1:0] wdata_d;
    logic [VMEM_B-1:0] be_d;
    lsu_state_t        state_d;

    logic              req_valid_q;
    lsu_state_t        req_state_q;
    logic [31:0]       req_addr_q;
    logic [VMEM_W-1:0] req_wdata_q;
    logic [VMEM_B-1:0] req_be_q;

    logic              q_ready;
    logic              suppress;
    logic              req_done;

    vlsu_addr_gen addr_gen_i (
        .in_first_i   (in_first_i),
        .in_stride_i  (in_stride_i),
        .in_eew_i     (in_eew_i),
        .in_masked_i  (in_masked_i),
        .in_xval_i    (in_xval_i),
        .in_vs_i      (in_vs_i),
        .in_mask_i    (in_mask_i),
        .in_vl_part_i (in_vl_part_i),
        .in_vl_zero_i (in_vl_zero_i),
        .in_valid_i   (in_valid_i),
        .prev_addr_i  (req_addr_q),
        .addr_o       (addr_d),
        .wdata_o      (wdata_d),
        .be_o         (be_d)
    );

    always_comb begin
        state_d.id      = in_id_i;
        state_d.first   = in_first_i;
        state_d.last    = in_last_i;
        state_d.store   = in_store_i;
        state_d.stride  = in_stride_i;
        state_d.eew     = in_eew_i;
        state_d.masked  = in_masked_i;
        state_d.vl_part = in_vl_part_i;
        state_d.vl_zero = in_vl_zero_i;
        state_d.off     = addr_d[OFF_W-1:0];
        state_d.mask    = in_mask_i;
    end

    ////////////////////////////////////////////////////////////
    // request register

    // a beat with no valid element never goes to memory
    assign suppress = req_state_q.vl_zero;

    // a suppressed beat waits for an empty queue so that it reaches the
    // head before any later memory result can come back
    assign req_done   = req_valid_q &
                        (suppress ? ~deq_valid_o : (q_ready & mem_ready_i));
    assign in_ready_o = ~req_valid_q | req_done;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            req_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            req_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            req_state_q <= state_d;
            req_addr_q  <= addr_d;
            req_wdata_q <= wdata_d;
            req_be_q    <= be_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory request, word aligned

    assign mem_valid_o = req_valid_q & ~suppress & q_ready;
    assign mem_addr_o  = {req_addr_q[31:OFF_W], {OFF_W{1'b0}}};
    assign mem_we_o    = req_state_q.store;
    assign mem_be_o    = req_be_q;
    assign mem_wdata_o = req_wdata_q;
    assign mem_last_o  = req_state_q.last;

    vlsu_queue #(
        .WIDTH ($bits(lsu_state_t)),
        .DEPTH (QUEUE_DEPTH)
    ) queue_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .enq_valid_i  (req_done),
        .enq_ready_o  (q_ready),
        .enq_data_i   (req_state_q),
        .deq_valid_o  (deq_valid_o),
        .deq_ready_i  (deq_ready_i),
        .deq_data_o   (deq_state_o)
    );

endmodule

`default_nettype wire

// ==== vlsu_result.sv ====
// result stage of the load/store unit
// dequeues on memory results, tracks bus errors, extracts load elements
`timescale 1ns/1ps
`default_nettype none

module vlsu_result import vlsu_pkg::*; (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic              deq_valid_i,
    output logic              deq_ready_o,
    input  lsu_state_t        deq_state_i,
    input  logic              mem_rvalid_i,
    input  logic [VMEM_W-1:0] mem_rdata_i,
    input  logic              mem_err_i,
    output logic              out_valid_o,
    output logic [VMEM_W-1:0] out_res_o,
    output logic [VMEM_B-1:0] out_mask_o,
    output logic              done_valid_o,
    output logic [ID_W-1:0]   done_id_o,
    output logic              done_exc_o,
    output logic [5:0]        done_exccode_o
);

    logic              deq;
    logic              err_q;
    logic              err_d;
    logic              out_valid_q;
    lsu_state_t        st_q;
    logic [VMEM_W-1:0] rdata_q;
    logic [VMEM_B-1:0] vl_mask;
    logic              stri_en;

    // results come back in order, a suppressed head needs no result
    assign deq_ready_o = mem_rvalid_i | deq_state_i.vl_zero;
    assign deq         = deq_valid_i & deq_ready_o;

    ////////////////////////////////////////////////////////////
    // error tracking per instruction

    always_comb begin
        err_d = err_q;
        if (deq) begin
            err_d = (deq_state_i.first ? 1'b0 : err_q) | (mem_rvalid_i & mem_err_i);
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            err_q       <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            err_q       <= err_d;
            out_valid_q <= deq;
        end
    end

    assign done_valid_o   = deq & deq_state_i.last;
    assign done_id_o      = deq_state_i.id;
    assign done_exc_o     = err_d;
    assign done_exccode_o = deq_state_i.store ? EXC_STORE_FAULT : EXC_LOAD_FAULT;

    ////////////////////////////////////////////////////////////
    // load data register and element extraction

    always_ff @(posedge clk_i) begin
        if (deq) begin
            st_q    <= deq_state_i;
            rdata_q <= mem_rdata_i;
        end
    end

    assign vl_mask = st_q.vl_zero ? '0 : ({VMEM_B{1'b1}} >> (~st_q.vl_part));
    assign stri_en = ~st_q.vl_zero & (st_q.masked ? st_q.mask[0] : 1'b1);

    assign out_valid_o = out_valid_q;

    always_comb begin
        out_res_o  = rdata_q;
        out_mask_o = (st_q.masked ? st_q.mask : {VMEM_B{1'b1}}) & vl_mask;
        if (st_q.stride == STRIDE_CONST) begin
            // element moved down to bit 0, one mask bit for the whole word
            out_res_o  = '0;
            out_mask_o = {VMEM_B{stri_en}};
            unique case (st_q.eew)
                EEW_8:   out_res_o[7:0]  = rdata_q[{st_q.off, 3'b000} +: 8];
                EEW_16:  out_res_o[15:0] = rdata_q[{st_q.off[OFF_W-1:1], 4'b0000} +: 16];
                default: out_res_o       = rdata_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== vlsu_top.sv ====
// vector load/store unit top level
// request stage with its queue, followed by the result stage
`timescale 1ns/1ps
`default_nettype none

module vlsu_top import vlsu_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    // input beats
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  logic              in_first_i,
    input  logic              in_last_i,
    input  logic              in_store_i,
    input  stride_e           in_stride_i,
    input  eew_e              in_eew_i,
    input  logic              in_masked_i,
    input  logic [31:0]       in_xval_i,
    input  logic [VMEM_W-1:0] in_vs_i,
    input  logic [VMEM_B-1:0] in_mask_i,
    input  logic [OFF_W-1:0]  in_vl_part_i,
    input  logic              in_vl_zero_i,
    // memory request and result
    output logic              mem_valid_o,
    input  logic              mem_ready_i,
    output logic [31:0]       mem_addr_o,
    output logic              mem_we_o,
    output logic [VMEM_B-1:0] mem_be_o,
    output logic [VMEM_W-1:0] mem_wdata_o,
    output logic              mem_last_o,
    input  logic              mem_rvalid_i,
    input  logic [VMEM_W-1:0] mem_rdata_i,
    input  logic              mem_err_i,
    // load results and completion
    output logic              out_valid_o,
    output logic [VMEM_W-1:0] out_res_o,
    output logic [VMEM_B-1:0] out_mask_o,
    output logic              done_valid_o,
    output logic [ID_W-1:0]   done_id_o,
    output logic              done_exc_o,
    output logic [5:0]        done_exccode_o
);

    logic       deq_valid;
    logic       deq_ready;
    lsu_state_t deq_state;

    vlsu_req_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) req_stage_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_id_i      (in_id_i),
        .in_first_i   (in_first_i),
        .in_last_i    (in_last_i),
        .in_store_i   (in_store_i),
        .in_stride_i  (in_stride_i),
        .in_eew_i     (in_eew_i),
        .in_masked_i  (in_masked_i),
        .in_xval_i    (in_xval_i),
        .in_vs_i      (in_vs_i),
        .in_mask_i    (in_mask_i),
        .in_vl_part_i (in_vl_part_i),
        .in_vl_zero_i (in_vl_zero_i),
        .mem_valid_o  (mem_valid_o),
        .mem_ready_i  (mem_ready_i),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_be_o     (mem_be_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_last_o   (mem_last_o),
        .deq_valid_o  (deq_valid),
        .deq_ready_i  (deq_ready),
        .deq_state_o  (deq_state)
    );

    vlsu_result result_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .deq_valid_i    (deq_valid),
        .deq_ready_o    (deq_ready),
        .deq_state_i    (deq_state),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_err_i      (mem_err_i),
        .out_valid_o    (out_valid_o),
        .out_res_o      (out_res_o),
        .out_mask_o     (out_mask_o),
        .done_valid_o   (done_valid_o),
        .done_id_o      (done_id_o),
        .done_exc_o     (done_exc_o),
        .done_exccode_o (done_exccode_o)
    );

endmodule

`default_nettype wire

// ==== tb_vlsu_mem.sv ====
// memory model for the load/store unit testbench
// answers one request at a time, in order, after a random delay
`timescale 1ns/1ps
`default_nettype none

module tb_vlsu_mem #(
    parameter int unsigned WORDS = 256
) (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  logic [31:0] req_addr_i,
    input  logic        req_we_i,
    input  logic [3:0]  req_be_i,
    input  logic [31:0] req_wdata_i,
    output logic        rvalid_o,
    output logic [31:0] rdata_o,
    output logic        err_o
);

    localparam int unsigned IDX_W = $clog2(WORDS);

    logic [31:0]      mem_q [WORDS];
    logic             busy_q;
    logic [1:0]       wait_q;
    logic [IDX_W-1:0] idx_q;
    logic             err_q;
    logic [IDX_W-1:0] idx;
    logic             hit_err;
    integer           seed;
    integer           draw;

    initial seed = 78;

    assign req_ready_o = ~busy_q;
    assign idx         = req_addr_i[IDX_W+1:2];

    // bus error window
    assign hit_err = (req_addr_i >= 32'h100) && (req_addr_i <= 32'h10F);

    always @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            for (int i = 0; i < WORDS; i++) begin
                mem_q[i] <= 32'(i) * 32'h01010101 + 32'h03020100;
            end
            busy_q   <= 1'b0;
            wait_q   <= 2'd0;
            idx_q    <= '0;
            err_q    <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o  <= 32'h0;
            err_o    <= 1'b0;
        end else begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
            if (req_valid_i && !busy_q) begin
                draw   = $random(seed);
                busy_q <= 1'b1;
                wait_q <= draw[1:0];
                idx_q  <= idx;
                err_q  <= hit_err;
                // a faulting store leaves the word untouched
                if (req_we_i && !hit_err) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_be_i[b]) begin
                            mem_q[idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                        end
                    end
                end
            end else if (busy_q) begin
                if (wait_q == 2'd0) begin
                    busy_q   <= 1'b0;
                    rvalid_o <= 1'b1;
                    rdata_o  <= mem_q[idx_q];
                    err_o    <= err_q;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_vlsu.sv ====
// testbench for the vector load/store unit
// applies a table of beats, checks requests, results and completions
`timescale 1ns/1ps
`default_nettype none

module tb_vlsu import vlsu_pkg::*; ();

    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic              first;
        logic              last;
        logic              store;
        stride_e           stride;
        eew_e              eew;
        logic              masked;
        logic [31:0]       xval;
        logic [VMEM_W-1:0] vs;
        logic [VMEM_B-1:0] mask;
        logic [OFF_W-1:0]  vl_part;
        logic              vl_zero;
        logic [31:0]       exp_addr;
        logic [VMEM_B-1:0] exp_be;
        logic [VMEM_W-1:0] exp_wdata;
        logic [VMEM_W-1:0] exp_res;
        logic [VMEM_B-1:0] exp_mask;
        logic [5:0]        exp_code;
    } beat_t;

    logic              clk_i;
    logic              async_rst_ni;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [ID_W-1:0]   in_id_i;
    logic              in_first_i;
    logic              in_last_i;
    logic              in_store_i;
    stride_e           in_stride_i;
    eew_e              in_eew_i;
    logic              in_masked_i;
    logic [31:0]       in_xval_i;
    logic [VMEM_W-1:0] in_vs_i;
    logic [VMEM_B-1:0] in_mask_i;
    logic [OFF_W-1:0]  in_vl_part_i;
    logic              in_vl_zero_i;
    logic              mem_valid_o;
    logic              mem_ready_i;
    logic [31:0]       mem_addr_o;
    logic              mem_we_o;
    logic [VMEM_B-1:0] mem_be_o;
    logic [VMEM_W-1:0] mem_wdata_o;
    logic              mem_last_o;
    logic              mem_rvalid_i;
    logic [VMEM_W-1:0] mem_rdata_i;
    logic              mem_err_i;
    logic              out_valid_o;
    logic [VMEM_W-1:0] out_res_o;
    logic [VMEM_B-1:0] out_mask_o;
    logic              done_valid_o;
    logic [ID_W-1:0]   done_id_o;
    logic              done_exc_o;
    logic [5:0]        done_exccode_o;

    beat_t rows [$];
    int    errors;
    logic  hung;

    vlsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH_DEF)
    ) vlsu_top_i (
        .clk_i, .async_rst_ni, .in_valid_i, .in_ready_o, .in_id_i, .in_first_i,
        .in_last_i, .in_store_i, .in_stride_i, .in_eew_i, .in_masked_i, .in_xval_i,
        .in_vs_i, .in_mask_i, .in_vl_part_i, .in_vl_zero_i, .mem_valid_o, .mem_ready_i,
        .mem_addr_o, .mem_we_o, .mem_be_o, .mem_wdata_o, .mem_last_o, .mem_rvalid_i,
        .mem_rdata_i, .mem_err_i, .out_valid_o, .out_res_o, .out_mask_o, .done_valid_o,
        .done_id_o, .done_exc_o, .done_exccode_o
    );

    tb_vlsu_mem mem_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .req_valid_i  (mem_valid_o),
        .req_ready_o  (mem_ready_i),
        .req_addr_i   (mem_addr_o),
        .req_we_i     (mem_we_o),
        .req_be_i     (mem_be_o),
        .req_wdata_i  (mem_wdata_o),
        .rvalid_o     (mem_rvalid_i),
        .rdata_o      (mem_rdata_i),
        .err_o        (mem_err_i)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // stimulus table
    // id first last store stride eew masked xval vs mask vl_part vl_zero
    // then expected mem_addr be wdata, load result and mask, fault code

    task automatic fill_table();
        // unit-stride store from 0x40
        rows.push_back(beat_t'{3'd1, 1'b1, 1'b0, 1'b1, STRIDE_UNIT, EEW_8, 1'b1, 32'h40,
            32'hA1B2C3D4, 4'b1011, 2'd3, 1'b0, 32'h40, 4'b1011, 32'hA1B2C3D4, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd1, 1'b0, 1'b0, 1'b1, STRIDE_UNIT, EEW_8, 1'b1, 32'h0,
            32'h11223344, 4'b1111, 2'd3, 1'b0, 32'h44, 4'b1111, 32'h11223344, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd1, 1'b0, 1'b1, 1'b1, STRIDE_UNIT, EEW_8, 1'b1, 32'h0,
            32'h55667788, 4'b1110, 2'd1, 1'b0, 32'h48, 4'b0010, 32'h55667788, 32'h0, 4'h0, 6'd0});
        // strided stores, stride 6
        rows.push_back(beat_t'{3'd2, 1'b1, 1'b0, 1'b1, STRIDE_CONST, EEW_16, 1'b0, 32'h60,
            32'h0000BEEF, 4'hF, 2'd3, 1'b0, 32'h60, 4'b0011, 32'hBEEFBEEF, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd2, 1'b0, 1'b1, 1'b1, STRIDE_CONST, EEW_16, 1'b0, 32'h6,
            32'h1234CAFE, 4'hF, 2'd3, 1'b0, 32'h64, 4'b1100, 32'hCAFECAFE, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd3, 1'b1, 1'b0, 1'b1, STRIDE_CONST, EEW_8, 1'b0, 32'h81,
            32'h00000077, 4'hF, 2'd3, 1'b0, 32'h80, 4'b0010, 32'h77777777, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd3, 1'b0, 1'b1, 1'b1, STRIDE_CONST, EEW_8, 1'b0, 32'h6,
            32'h00000099, 4'hF, 2'd3, 1'b0, 32'h84, 4'b1000, 32'h99999999, 32'h0, 4'h0, 6'd0});
        // unit-stride load from 0x20
        rows.push_back(beat_t'{3'd4, 1'b1, 1'b0, 1'b0, STRIDE_UNIT, EEW_32, 1'b1, 32'h20,
            32'h0, 4'b1101, 2'd3, 1'b0, 32'h20, 4'b1101, 32'h0, 32'h0B0A0908, 4'b1101, 6'd0});
        rows.push_back(beat_t'{3'd4, 1'b0, 1'b1, 1'b0, STRIDE_UNIT, EEW_32, 1'b0, 32'h0,
            32'h0, 4'hF, 2'd2, 1'b0, 32'h24, 4'b0111, 32'h0, 32'h0C0B0A09, 4'b0111, 6'd0});
        // strided loads, stride 6
        rows.push_back(beat_t'{3'd5, 1'b1, 1'b0, 1'b0, STRIDE_CONST, EEW_8, 1'b0, 32'h33,
            32'h0, 4'hF, 2'd3, 1'b0, 32'h30, 4'b1000, 32'h0, 32'h0000000F, 4'hF, 6'd0});
        rows.push_back(beat_t'{3'd5, 1'b0, 1'b1, 1'b0, STRIDE_CONST, EEW_8, 1'b1, 32'h6,
            32'h0, 4'b1110, 2'd3, 1'b0, 32'h38, 4'b0000, 32'h0, 32'h0000000F, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd6, 1'b1, 1'b1, 1'b0, STRIDE_CONST, EEW_16, 1'b0, 32'h52,
            32'h0, 4'hF, 2'd3, 1'b0, 32'h50, 4'b1100, 32'h0, 32'h00001716, 4'hF, 6'd0});
        // bus errors, sticky over the instruction
        rows.push_back(beat_t'{3'd7, 1'b1, 1'b0, 1'b0, STRIDE_UNIT, EEW_32, 1'b0, 32'h10C,
            32'h0, 4'hF, 2'd3, 1'b0, 32'h10C, 4'hF, 32'h0, 32'h46454443, 4'hF, 6'd0});
        rows.push_back(beat_t'{3'd7, 1'b0, 1'b1, 1'b0, STRIDE_UNIT, EEW_32, 1'b0, 32'h0,
            32'h0, 4'hF, 2'd3, 1'b0, 32'h110, 4'hF, 32'h0, 32'h47464544, 4'hF, 6'd5});
        rows.push_back(beat_t'{3'd0, 1'b1, 1'b0, 1'b1, STRIDE_UNIT, EEW_32, 1'b0, 32'hFC,
            32'hDEADBEEF, 4'hF, 2'd3, 1'b0, 32'hFC, 4'hF, 32'hDEADBEEF, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd0, 1'b0, 1'b1, 1'b1, STRIDE_UNIT, EEW_32, 1'b0, 32'h0,
            32'h01234567, 4'hF, 2'd3, 1'b0, 32'h100, 4'hF, 32'h01234567, 32'h0, 4'h0, 6'd7});
        rows.push_back(beat_t'{3'd1, 1'b1, 1'b1, 1'b0, STRIDE_UNIT, EEW_32, 1'b0, 32'h20,
            32'h0, 4'hF, 2'd3, 1'b0, 32'h20, 4'hF, 32'h0, 32'h0B0A0908, 4'hF, 6'd0});
        // beats with no valid element
        rows.push_back(beat_t'{3'd2, 1'b1, 1'b1, 1'b0, STRIDE_UNIT, EEW_32, 1'b0, 32'h24,
            32'h0, 4'hF, 2'd3, 1'b1, 32'h0, 4'h0, 32'h0, 32'h0, 4'h0, 6'd0});
        rows.push_back(beat_t'{3'd3, 1'b1, 1'b1, 1'b0, STRIDE_CONST, EEW_8, 1'b0, 32'h31,
            32'h0, 4'hF, 2'd3, 1'b1, 32'h0, 4'h0, 32'h0, 32'h0, 4'h0, 6'd0});
    endtask

    ////////////////////////////////////////////////////////////
    // checking helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        hung = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic run_beat(input beat_t b);
        int              n;
        logic            seen_done;
        logic [ID_W-1:0] got_id;
        logic            got_exc;
        logic [5:0]      got_code;
        seen_done = 1'b0;
        got_id    = '0;
        got_exc   = 1'b0;
        got_code  = '0;
        @(posedge clk_i);
        #1;
        in_valid_i   = 1'b1;
        in_id_i      = b.id;
        in_first_i   = b.first;
        in_last_i    = b.last;
        in_store_i   = b.store;
        in_stride_i  = b.stride;
        in_eew_i     = b.eew;
        in_masked_i  = b.masked;
        in_xval_i    = b.xval;
        in_vs_i      = b.vs;
        in_mask_i    = b.mask;
        in_vl_part_i = b.vl_part;
        in_vl_zero_i = b.vl_zero;
        n = 0;
        @(negedge clk_i);
        while (!in_ready_o) begin
            if (n == TIMEOUT) begin
                note_timeout("input acceptance");
                return;
            end
            n++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
        @(negedge clk_i);
        if (!b.vl_zero) begin
            n = 0;
            while (!(mem_valid_o && mem_ready_i)) begin
                if (n == TIMEOUT) begin
                    note_timeout("memory request");
                    return;
                end
                n++;
                @(negedge clk_i);
            end
            check_value("mem_addr_o", mem_addr_o, b.exp_addr);
            check_value("mem_be_o", 32'(mem_be_o), 32'(b.exp_be));
            check_value("mem_we_o", 32'(mem_we_o), 32'(b.store));
            check_value("mem_last_o", 32'(mem_last_o), 32'(b.last));
            if (b.store) begin
                check_value("mem_wdata_o", mem_wdata_o, b.exp_wdata);
            end
        end
        // completion comes one cycle ahead of the result
        n = 0;
        while (!out_valid_o) begin
            if (b.vl_zero) begin
                assert (!mem_valid_o) else begin
                    errors++;
                    $display("memory request issued for a beat with no valid element");
                end
            end
            if (done_valid_o) begin
                seen_done = 1'b1;
                got_id    = done_id_o;
                got_exc   = done_exc_o;
                got_code  = done_exccode_o;
            end
            if (n == TIMEOUT) begin
                note_timeout("load result");
                return;
            end
            n++;
            @(negedge clk_i);
        end
        if (b.last) begin
            assert (seen_done) else begin
                errors++;
                $display("no completion for the last beat of id %0d", b.id);
            end
            check_value("done_id_o", 32'(got_id), 32'(b.id));
            check_value("done_exc_o", 32'(got_exc), 32'(b.exp_code != 6'd0));
            if (b.exp_code != 6'd0) begin
                check_value("done_exccode_o", 32'(got_code), 32'(b.exp_code));
            end
        end else begin
            assert (!seen_done) else begin
                errors++;
                $display("completion reported before the last beat of id %0d", b.id);
            end
        end
        if (!b.store) begin
            check_value("out_mask_o", 32'(out_mask_o), 32'(b.exp_mask));
            if (!b.vl_zero) begin
                check_value("out_res_o", out_res_o, b.exp_res);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        errors       = 0;
        hung         = 1'b0;
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        in_id_i      = '0;
        in_first_i   = 1'b0;
        in_last_i    = 1'b0;
        in_store_i   = 1'b0;
        in_stride_i  = STRIDE_UNIT;
        in_eew_i     = EEW_8;
        in_masked_i  = 1'b0;
        in_xval_i    = 32'h0;
        in_vs_i      = '0;
        in_mask_i    = '0;
        in_vl_part_i = '0;
        in_vl_zero_i = 1'b0;
        fill_table();
        repeat (16) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;
        @(negedge clk_i);
        assert (in_ready_o && !mem_valid_o && !out_valid_o && !done_valid_o) else begin
            errors++;
            $display("outputs not in their idle state after reset");
        end
        for (int r = 0; r < rows.size(); r++) begin
            run_beat(rows[r]);
            if (hung) begin
                break;
            end
        end
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
vlsu_pkg.sv
vlsu_addr_gen.sv
vlsu_queue.sv
vlsu_req_stage.sv
vlsu_result.sv
vlsu_top.sv
tb_vlsu_mem.sv
tb_vlsu.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_vlsu
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
